// ==== source/game_settings.svh ====
`ifndef GAME_SETTINGS_SVH
`define GAME_SETTINGS_SVH

// board is square, cells per side
`define GAME_SIDE 4

// tile holds the exponent of its value, 0 is an empty cell
`define GAME_TILE_BITS 4

// running score, wraps at the top
`define GAME_SCORE_BITS 12

// merges in one move, at most eight on a 4x4 board
`define GAME_POINT_BITS 4

`endif

// ==== source/game_pkg.sv ====
`include "game_settings.svh"

package game_pkg;

    typedef logic [`GAME_TILE_BITS-1:0] tile_t;

    // row-major, board[r][c] with column 0 on the left edge
    typedef tile_t [`GAME_SIDE-1:0] row_t;
    typedef row_t [`GAME_SIDE-1:0] board_t;

    typedef enum logic [3:0] {
        dir_left  = 4'b0001,
        dir_up    = 4'b0010,
        dir_down  = 4'b0100,
        dir_right = 4'b1000
    } move_dir_t;

    typedef enum logic [1:0] {
        status_active = 2'b00,
        status_win    = 2'b01,
        status_lose   = 2'b10
    } game_status_t;

    typedef logic [`GAME_POINT_BITS-1:0] points_t;
    typedef logic [`GAME_SCORE_BITS-1:0] score_t;

    // quarter turn counter-clockwise, top edge ends up on the left
    function automatic board_t rot_ccw(board_t b);
        board_t res;
        for (int r = 0; r < `GAME_SIDE; r++) begin
            for (int c = 0; c < `GAME_SIDE; c++) begin
                res[r][c] = b[c][`GAME_SIDE-1-r];
            end
        end
        return res;
    endfunction

    // quarter turn clockwise, bottom edge ends up on the left
    function automatic board_t rot_cw(board_t b);
        board_t res;
        for (int r = 0; r < `GAME_SIDE; r++) begin
            for (int c = 0; c < `GAME_SIDE; c++) begin
                res[r][c] = b[`GAME_SIDE-1-c][r];
            end
        end
        return res;
    endfunction

    function automatic board_t mirror_h(board_t b);
        board_t res;
        for (int r = 0; r < `GAME_SIDE; r++) begin
            for (int c = 0; c < `GAME_SIDE; c++) begin
                res[r][c] = b[r][`GAME_SIDE-1-c];
            end
        end
        return res;
    endfunction

    // push non-empty tiles to the left, order kept
    function automatic row_t compact_row(row_t row);
        row_t res;
        int unsigned k;
        res = '0;
        k = 0;
        for (int c = 0; c < `GAME_SIDE; c++) begin
            if (row[c] != '0) begin
                res[k] = row[c];
                k++;
            end
        end
        return res;
    endfunction

endpackage

// ==== source/game_stream_if.sv ====
`timescale 1ns/1ps

// board plus direction between the first three stages
interface board_stream_if import game_pkg::*; ();

    logic      valid;
    logic      ready;
    board_t    board;
    move_dir_t dir;

    modport sender (
        output valid,
        output board,
        output dir,
        input  ready
    );

    modport receiver (
        input  valid,
        input  board,
        input  dir,
        output ready
    );

endinterface

// merged board with its move result, into the last stage
interface scored_stream_if import game_pkg::*; ();

    logic      valid;
    logic      ready;
    board_t    board;
    move_dir_t dir;
    logic      moved;
    points_t   points;

    modport sender (
        output valid,
        output board,
        output dir,
        output moved,
        output points,
        input  ready
    );

    modport receiver (
        input  valid,
        input  board,
        input  dir,
        input  moved,
        input  points,
        output ready
    );

endinterface

// ==== source/orient_stage.sv ====
`timescale 1ns/1ps

module orient_stage import game_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    board_stream_if.receiver upstream,
    board_stream_if.sender   downstream
);

    logic      full;
    board_t    turned;
    board_t    board_q;
    move_dir_t dir_q;

    // every move is turned into a move to the left
    always_comb begin
        case (upstream.dir)
            dir_up:    turned = rot_ccw(upstream.board);
            dir_down:  turned = rot_cw(upstream.board);
            dir_right: turned = mirror_h(upstream.board);
            default:   turned = upstream.board;
        endcase
    end

    // slot frees up when the next stage takes the item
    assign upstream.ready = !full || downstream.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (upstream.ready) begin
            full <= upstream.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (upstream.valid && upstream.ready) begin
            board_q <= turned;
            // dir rides along so the last stage can turn it back
            dir_q   <= upstream.dir;
        end
    end

    assign downstream.valid = full;
    assign downstream.board = board_q;
    assign downstream.dir   = dir_q;

endmodule

// ==== source/slide_stage.sv ====
`timescale 1ns/1ps
`include "game_settings.svh"

module slide_stage import game_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    board_stream_if.receiver upstream,
    board_stream_if.sender   downstream,
    output logic             shifted
);

    logic      full;
    board_t    slid;
    board_t    board_q;
    move_dir_t dir_q;
    logic      shifted_q;

    always_comb begin
        for (int r = 0; r < `GAME_SIDE; r++) begin
            slid[r] = compact_row(upstream.board[r]);
        end
    end

    assign upstream.ready = !full || downstream.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (upstream.ready) begin
            full <= upstream.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (upstream.valid && upstream.ready) begin
            board_q   <= slid;
            dir_q     <= upstream.dir;
            // compaction only changes the board when some tile moved
            shifted_q <= (slid != upstream.board);
        end
    end

    assign downstream.valid = full;
    assign downstream.board = board_q;
    assign downstream.dir   = dir_q;
    assign shifted          = shifted_q;

endmodule

// ==== source/merge_stage.sv ====
`timescale 1ns/1ps
`include "game_settings.svh"

module merge_stage import game_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    board_stream_if.receiver upstream,
    input  logic             shifted,
    scored_stream_if.sender  downstream
);

    logic      full;
    board_t    merged;
    points_t   merges;
    board_t    board_q;
    move_dir_t dir_q;
    logic      moved_q;
    points_t   points_q;

    // rows arrive compacted, so equal pairs sit next to each other
    always_comb begin : pair_merge
        row_t    row;
        points_t cnt;
        cnt = '0;
        for (int r = 0; r < `GAME_SIDE; r++) begin
            row = upstream.board[r];
            // a merge empties the right cell of its pair
            for (int c = 0; c < `GAME_SIDE - 1; c++) begin
                if (row[c] != '0 && row[c] == row[c+1]) begin
                    row[c]   = row[c] + tile_t'(1);
                    row[c+1] = '0;
                    cnt      = cnt + points_t'(1);
                end
            end
            // close the gaps left by the merges
            merged[r] = compact_row(row);
        end
        merges = cnt;
    end

    assign upstream.ready = !full || downstream.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (upstream.ready) begin
            full <= upstream.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (upstream.valid && upstream.ready) begin
            board_q  <= merged;
            dir_q    <= upstream.dir;
            moved_q  <= shifted || (merges != '0);
            points_q <= merges;
        end
    end

    assign downstream.valid  = full;
    assign downstream.board  = board_q;
    assign downstream.dir    = dir_q;
    assign downstream.moved  = moved_q;
    assign downstream.points = points_q;

endmodule

// ==== source/restore_eval_stage.sv ====
`timescale 1ns/1ps
`include "game_settings.svh"

module restore_eval_stage import game_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    scored_stream_if.receiver upstream,
    input  tile_t             goal,
    output logic              out_valid,
    input  logic              out_ready,
    output board_t            out_board,
    output logic              out_moved,
    output points_t           out_points,
    output score_t            out_score,
    output game_status_t      out_status
);

    logic         full;
    board_t       restored;
    game_status_t status;
    logic         has_goal;
    logic         has_empty;
    logic         has_pair;
    score_t       score_q;

    // inverse of the orient stage turn
    always_comb begin
        case (upstream.dir)
            dir_up:    restored = rot_cw(upstream.board);
            dir_down:  restored = rot_ccw(upstream.board);
            dir_right: restored = mirror_h(upstream.board);
            default:   restored = upstream.board;
        endcase
    end

    always_comb begin
        has_goal  = 1'b0;
        has_empty = 1'b0;
        has_pair  = 1'b0;
        for (int r = 0; r < `GAME_SIDE; r++) begin
            for (int c = 0; c < `GAME_SIDE; c++) begin
                if (restored[r][c] == goal) has_goal = 1'b1;
                if (restored[r][c] == '0) has_empty = 1'b1;
            end
        end
        // horizontal neighbours
        for (int r = 0; r < `GAME_SIDE; r++) begin
            for (int c = 0; c < `GAME_SIDE - 1; c++) begin
                if (restored[r][c] == restored[r][c+1]) has_pair = 1'b1;
            end
        end
        // vertical neighbours
        for (int r = 0; r < `GAME_SIDE - 1; r++) begin
            for (int c = 0; c < `GAME_SIDE; c++) begin
                if (restored[r][c] == restored[r+1][c]) has_pair = 1'b1;
            end
        end
        // win beats lose
        if (has_goal) status = status_win;
        else if (!has_empty && !has_pair) status = status_lose;
        else status = status_active;
    end

    assign upstream.ready = !full || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            full       <= 1'b0;
            score_q    <= '0;
            out_status <= status_active;
        end else begin
            if (upstream.ready) full <= upstream.valid;
            if (upstream.valid && upstream.ready) begin
                score_q    <= score_q + score_t'(upstream.points);
                out_status <= status;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (upstream.valid && upstream.ready) begin
            out_board  <= restored;
            out_moved  <= upstream.moved;
            out_points <= upstream.points;
        end
    end

    assign out_valid = full;
    assign out_score = score_q;

endmodule

// ==== source/move_engine_top.sv ====
`timescale 1ns/1ps

module move_engine_top import game_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         in_valid,
    output logic         in_ready,
    input  board_t       in_board,
    input  move_dir_t    in_dir,
    input  tile_t        goal,
    output logic         out_valid,
    input  logic         out_ready,
    output board_t       out_board,
    output logic         out_moved,
    output points_t      out_points,
    output score_t       out_score,
    output game_status_t out_status
);

    logic shifted;

    board_stream_if  in_link ();
    board_stream_if  orient_link ();
    board_stream_if  slide_link ();
    scored_stream_if merge_link ();

    // plain input ports onto the first link
    assign in_link.valid = in_valid;
    assign in_link.board = in_board;
    assign in_link.dir   = in_dir;
    assign in_ready      = in_link.ready;

    orient_stage u_orient (
        .clk        (clk),
        .reset      (reset),
        .upstream   (in_link),
        .downstream (orient_link)
    );

    slide_stage u_slide (
        .clk        (clk),
        .reset      (reset),
        .upstream   (orient_link),
        .downstream (slide_link),
        .shifted    (shifted)
    );

    merge_stage u_merge (
        .clk        (clk),
        .reset      (reset),
        .upstream   (slide_link),
        .shifted    (shifted),
        .downstream (merge_link)
    );

    restore_eval_stage u_restore_eval (
        .clk        (clk),
        .reset      (reset),
        .upstream   (merge_link),
        .goal       (goal),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_board  (out_board),
        .out_moved  (out_moved),
        .out_points (out_points),
        .out_score  (out_score),
        .out_status (out_status)
    );

endmodule

// ==== tb/move_engine_properties.sv ====
`timescale 1ns/1ps

module move_engine_properties import game_pkg::*; (
    input logic         clk,
    input logic         reset,
    input logic         in_valid,
    input move_dir_t    in_dir,
    input logic         out_valid,
    input logic         out_ready,
    input board_t       out_board,
    input logic         out_moved,
    input points_t      out_points,
    input score_t       out_score,
    input game_status_t out_status
);

    // the stages never decode a direction outside one-hot
    in_dir_onehot: assert property (@(posedge clk) disable iff (reset)
        in_valid |-> $onehot(in_dir))
        else $error("in_dir is not one-hot while in_valid is high");

    // a stalled result holds until the sink takes it
    out_held_on_stall: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_board)
            && $stable(out_moved) && $stable(out_points)
            && $stable(out_score) && $stable(out_status)))
        else $error("output changed while out_valid was high and out_ready low");

    reset_clears_out_valid: assert property (@(posedge clk)
        reset |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

endmodule

bind move_engine_top move_engine_properties u_properties (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_dir     (in_dir),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_board  (out_board),
    .out_moved  (out_moved),
    .out_points (out_points),
    .out_score  (out_score),
    .out_status (out_status)
);

// ==== tb/move_engine_tb.sv ====
`timescale 1ns/1ps
`include "game_settings.svh"

module move_engine_tb import game_pkg::*; ();

    localparam int NUM_MOVES   = 400;
    localparam int CYCLE_LIMIT = NUM_MOVES * 8 + 200;
    localparam int LATENCY     = 4;

    logic         clk;
    logic         reset;
    logic         in_valid;
    logic         in_ready;
    board_t       in_board;
    move_dir_t    in_dir;
    tile_t        goal;
    logic         out_valid;
    logic         out_ready;
    board_t       out_board;
    logic         out_moved;
    points_t      out_points;
    score_t       out_score;
    game_status_t out_status;

    integer seed;
    int     cycle;
    int     checked;
    logic   hold_ready;
    score_t model_score;

    // expected results with the oldest first
    board_t       exp_board_q[$];
    logic         exp_moved_q[$];
    points_t      exp_points_q[$];
    score_t       exp_score_q[$];
    game_status_t exp_status_q[$];
    int           accept_cycle_q[$];
    logic         timed_q[$];

    move_engine_top u_move_engine_top (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_board   (in_board),
        .in_dir     (in_dir),
        .goal       (goal),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_board  (out_board),
        .out_moved  (out_moved),
        .out_points (out_points),
        .out_score  (out_score),
        .out_status (out_status)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // sink stalls at random unless a timed stretch holds it ready
    always @(posedge clk) begin
        if (hold_ready) begin
            out_ready <= 1'b1;
        end else begin
            out_ready <= (rand_below(3) != 0);
        end
    end

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic board_t random_board();
        board_t b;
        for (int r = 0; r < `GAME_SIDE; r++) begin
            for (int c = 0; c < `GAME_SIDE; c++) begin
                if (rand_below(100) < 40) begin
                    b[r][c] = '0;
                end else begin
                    b[r][c] = tile_t'(1 + rand_below(10));
                end
            end
        end
        return b;
    endfunction

    // full board where each tile differs from its left and upper neighbour
    function automatic board_t lose_board();
        board_t b;
        tile_t  v;
        for (int r = 0; r < `GAME_SIDE; r++) begin
            for (int c = 0; c < `GAME_SIDE; c++) begin
                v = tile_t'(1 + rand_below(10));
                while ((c > 0 && v == b[r][c-1]) || (r > 0 && v == b[r-1][c])) begin
                    v = (v == 4'd10) ? 4'd1 : v + 4'd1;
                end
                b[r][c] = v;
            end
        end
        return b;
    endfunction

    function automatic move_dir_t random_dir();
        case (rand_below(4))
            0:       return dir_left;
            1:       return dir_up;
            2:       return dir_down;
            default: return dir_right;
        endcase
    endfunction

    // cell k of line i with k counted from the edge the tiles move towards
    function automatic int line_row(move_dir_t d, int i, int k);
        case (d)
            dir_up:   return k;
            dir_down: return `GAME_SIDE - 1 - k;
            default:  return i;
        endcase
    endfunction

    function automatic int line_col(move_dir_t d, int i, int k);
        case (d)
            dir_up, dir_down: return i;
            dir_right:        return `GAME_SIDE - 1 - k;
            default:          return k;
        endcase
    endfunction

    task automatic move_line(input row_t line, output row_t res, output int merges);
        row_t tiles;
        int   n;
        int   j;
        tiles = '0;
        n     = 0;
        for (int k = 0; k < `GAME_SIDE; k++) begin
            if (line[k] != '0) begin
                tiles[n] = line[k];
                n++;
            end
        end
        res    = '0;
        merges = 0;
        j      = 0;
        n      = 0;
        // a merged tile is consumed, so it never merges twice
        while (j < `GAME_SIDE && tiles[j] != '0) begin
            if (j + 1 < `GAME_SIDE && tiles[j] == tiles[j+1]) begin
                res[n] = tiles[j] + 4'd1;
                merges++;
                j += 2;
            end else begin
                res[n] = tiles[j];
                j += 1;
            end
            n++;
        end
    endtask

    task automatic apply_move(input board_t b, input move_dir_t d,
                              output board_t res, output points_t pts);
        row_t line;
        row_t done;
        int   merges;
        int   total;
        total = 0;
        for (int i = 0; i < `GAME_SIDE; i++) begin
            for (int k = 0; k < `GAME_SIDE; k++) begin
                line[k] = b[line_row(d, i, k)][line_col(d, i, k)];
            end
            move_line(line, done, merges);
            total += merges;
            for (int k = 0; k < `GAME_SIDE; k++) begin
                res[line_row(d, i, k)][line_col(d, i, k)] = done[k];
            end
        end
        pts = points_t'(total);
    endtask

    function automatic game_status_t board_status(board_t b, tile_t g);
        logic win;
        logic empty;
        logic pair;
        win   = 1'b0;
        empty = 1'b0;
        pair  = 1'b0;
        for (int r = 0; r < `GAME_SIDE; r++) begin
            for (int c = 0; c < `GAME_SIDE; c++) begin
                if (b[r][c] == g) win = 1'b1;
                if (b[r][c] == '0) empty = 1'b1;
                if (c + 1 < `GAME_SIDE && b[r][c] == b[r][c+1]) pair = 1'b1;
                if (r + 1 < `GAME_SIDE && b[r][c] == b[r+1][c]) pair = 1'b1;
            end
        end
        if (win) return status_win;
        if (!empty && !pair) return status_lose;
        return status_active;
    endfunction

    task automatic record_expected(input board_t b, input move_dir_t d);
        board_t  res;
        points_t pts;
        apply_move(b, d, res, pts);
        model_score = model_score + score_t'(pts);
        exp_board_q.push_back(res);
        exp_moved_q.push_back(res != b);
        exp_points_q.push_back(pts);
        exp_score_q.push_back(model_score);
        exp_status_q.push_back(board_status(res, goal));
        accept_cycle_q.push_back(cycle);
        timed_q.push_back(hold_ready);
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at cycle %0d", cycle);
    endtask

    task automatic check_board(input string name, input board_t exp, input board_t act);
        if (act !== exp) begin
            abort_run($sformatf("** Error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("** Error: %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_number(input string name, input score_t exp, input score_t act);
        if (act !== exp) begin
            abort_run($sformatf("** Error: %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_status(input string name, input game_status_t exp,
                                input game_status_t act);
        if (act !== exp) begin
            abort_run($sformatf("** Error: %s expected %s actual %s",
                                name, exp.name(), act.name()));
        end
    endtask

    // starts on a rising edge and returns on the edge that takes the move
    task automatic drive_move(input board_t b, input move_dir_t d, input int idle);
        for (int k = 0; k < idle; k++) begin
            in_valid <= 1'b0;
            @(posedge clk);
        end
        in_valid <= 1'b1;
        in_board <= b;
        in_dir   <= d;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        record_expected(b, d);
        @(posedge clk);
    endtask

    task automatic drain_pipeline();
        while (exp_board_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    // goal only changes with the pipeline empty
    task automatic run_moves(input int count, input tile_t g, input logic back_to_back);
        board_t b;
        int     idle;
        drain_pipeline();
        goal       <= g;
        hold_ready <= back_to_back;
        repeat (2) @(posedge clk);
        for (int i = 0; i < count; i++) begin
            b    = (rand_below(8) == 0) ? lose_board() : random_board();
            idle = 0;
            if (!back_to_back && rand_below(4) == 0) begin
                idle = 1 + rand_below(3);
            end
            drive_move(b, random_dir(), idle);
        end
        in_valid <= 1'b0;
        drain_pipeline();
    endtask

    always @(negedge clk) begin : check_output
        string tag;
        int    wait_cycles;
        if (!reset && out_valid && out_ready) begin
            if (exp_board_q.size() == 0) begin
                abort_run("a result came out with no move pending");
            end else begin
                tag = $sformatf("move %0d", checked);
                check_board({tag, " board"}, exp_board_q[0], out_board);
                check_bit({tag, " moved"}, exp_moved_q[0], out_moved);
                check_number({tag, " points"}, score_t'(exp_points_q[0]),
                             score_t'(out_points));
                check_number({tag, " score"}, exp_score_q[0], out_score);
                check_status({tag, " status"}, exp_status_q[0], out_status);
                // score since reset holds only the first move's points
                if (checked == 0) begin
                    check_number({tag, " first score"}, score_t'(exp_points_q[0]),
                                 out_score);
                end
                if (timed_q[0]) begin
                    wait_cycles = cycle - accept_cycle_q[0];
                    if (wait_cycles != LATENCY) begin
                        abort_run($sformatf("** Error: %s latency expected %0d actual %0d",
                                            tag, LATENCY, wait_cycles));
                    end
                end
                void'(exp_board_q.pop_front());
                void'(exp_moved_q.pop_front());
                void'(exp_points_q.pop_front());
                void'(exp_score_q.pop_front());
                void'(exp_status_q.pop_front());
                void'(accept_cycle_q.pop_front());
                void'(timed_q.pop_front());
                checked++;
            end
        end
    end

    initial begin : watchdog
        wait (cycle >= CYCLE_LIMIT);
        abort_run($sformatf("timeout after %0d cycles, results stopped coming out", cycle));
    end

    initial begin : stimulus
        clk         = 1'b0;
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_board    = '0;
        in_dir      = dir_left;
        goal        = 4'd11;
        out_ready   = 1'b0;
        seed        = 32'h6ff1;
        cycle       = 0;
        checked     = 0;
        hold_ready  = 1'b0;
        model_score = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_bit("after reset out_valid", 1'b0, out_valid);
        check_bit("after reset in_ready", 1'b1, in_ready);
        @(posedge clk);
        run_moves(100, 4'd11, 1'b0);
        // low goal so merges reach it
        run_moves(60, 4'd3, 1'b0);
        // back to back with the sink always ready so latency can be checked
        run_moves(40, 4'd11, 1'b1);
        run_moves(200, 4'd11, 1'b0);
        repeat (10) @(posedge clk);
        if (checked == NUM_MOVES && exp_board_q.size() == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            abort_run($sformatf("only %0d of %0d moves came out", checked, NUM_MOVES));
        end
    end

endmodule

// ==== build.f ====
+incdir+source
source/game_pkg.sv
source/game_stream_if.sv
source/orient_stage.sv
source/slide_stage.sv
source/merge_stage.sv
source/restore_eval_stage.sv
source/move_engine_top.sv
tb/move_engine_properties.sv
tb/move_engine_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the move engine testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f \
    --top-module move_engine_tb -Mdir obj_dir -o move_engine_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/move_engine_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
